//--- verif/dbus_tests.txt
# op addr wdata exp_rdata exp_err
# all values hex, exp_err is 1 for an address outside the four banks
SW 10000000 11223344 00000000 0
SW 20000000 55667788 00000000 0
SW 30000000 99aabbcc 00000000 0
SW 40000000 ddeeff00 00000000 0
LW 10000000 00000000 11223344 0
LW 20000000 00000000 55667788 0
LW 30000000 00000000 99aabbcc 0
LW 40000000 00000000 ddeeff00 0
SW 10000010 aabbccdd 00000000 0
SB 10000011 000000ee 00000000 0
SH 10000012 00001234 00000000 0
SB 10000010 ffffff80 00000000 0
LW 10000010 00000000 1234ee80 0
LB 10000010 00000000 ffffff80 0
LBU 10000010 00000000 00000080 0
LB 10000011 00000000 ffffffee 0
LBU 10000011 00000000 000000ee 0
LH 10000010 00000000 ffffee80 0
LHU 10000010 00000000 0000ee80 0
LH 10000012 00000000 00001234 0
LH 40000002 00000000 ffffddee 0
LHU 40000002 00000000 0000ddee 0
LB 40000001 00000000 ffffffff 0
SB 20000000 0000005a 00000000 0
LW 10000000 00000000 11223344 0
LW 20000000 00000000 5566775a 0
LW 30000000 00000000 99aabbcc 0
SW 00000000 deadbeef 00000000 1
SW 50000000 deadbeef 00000000 1
LW f0000000 00000000 00000000 1
LW 10000000 00000000 11223344 0
LW 40000000 00000000 ddeeff00 0

//--- dbus_subsys_top.f
src/dbus_pkg.sv
src/dbus_if.sv
src/dbus_interconnect.sv
src/dmem_bank.sv
src/dbus_load_align.sv
src/dbus_subsys_top.sv
verif/dbus_subsys_tb.sv

//--- Bender.yml
package:
  name: dbus_subsys

sources:
  - src/dbus_pkg.sv
  - src/dbus_if.sv
  - src/dbus_interconnect.sv
  - src/dmem_bank.sv
  - src/dbus_load_align.sv
  - src/dbus_subsys_top.sv
  - target: test
    files:
      - verif/dbus_subsys_tb.sv

//--- verif/dbus_subsys_tb.sv
module dbus_subsys_tb
   import dbus_pkg::*;
();

   logic          clk = 1'b0;
   logic          rst_n;
   logic          ld_req;
   logic [2:0]    ld_ops;
   logic [1:0]    st_ops;
   logic [31:0]   addr;
   logic [31:0]   wdata;
   logic [31:0]   lsu_rdata;
   logic          lsu_ack;
   logic          lsu_err;

   // Vectors from the test file
   string         t_op [$];
   logic [31:0]   t_addr [$];
   logic [31:0]   t_wdata [$];
   logic [31:0]   t_rdata [$];
   logic          t_err [$];

   int            num_tests = 0;
   int            err_cnt = 0;
   int            pass_cnt = 0;
   int            fail_cnt = 0;
   int            cycle_cnt = 0;
   int            cycle_limit = 20;

   dbus_subsys_top u_dbus_subsys_top (
      .clk         (clk),
      .rst_n_i     (rst_n),
      .ld_req_i    (ld_req),
      .ld_ops_i    (ld_ops),
      .st_ops_i    (st_ops),
      .addr_i      (addr),
      .w_data_i    (wdata),
      .lsu_rdata_o (lsu_rdata),
      .lsu_ack_o   (lsu_ack),
      .lsu_err_o   (lsu_err)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
         $display("Timeout after %0d cycles, the DUT never acknowledged a request", cycle_cnt);
         $display("Testbench failed");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("error at %0t: %s expected %h actual %h", $time, name, expected, actual);
         err_cnt++;
      end
   endtask

   task automatic load_tests();
      int            fd;
      int            n;
      string         line;
      string         op;
      logic [31:0]   a;
      logic [31:0]   wd;
      logic [31:0]   rd;
      logic [31:0]   er;
      fd = $fopen("verif/dbus_tests.txt", "r");
      if (fd == 0) begin
         $display("Cannot open verif/dbus_tests.txt, no tests to run");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() == 0 || line[0] == "#") continue;   // Blank or comment
         n = $sscanf(line, "%s %h %h %h %h", op, a, wd, rd, er);
         if (n == 5) begin
            t_op.push_back(op);
            t_addr.push_back(a);
            t_wdata.push_back(wd);
            t_rdata.push_back(rd);
            t_err.push_back(er[0]);
         end
      end
      $fclose(fd);
      num_tests = t_op.size();
   endtask

   task automatic drive_request(input string op, input logic [31:0] a, input logic [31:0] wd);
      addr  = a;
      wdata = wd;
      case (op)
         "LB":    ld_ops = LD_OPS_LB;
         "LH":    ld_ops = LD_OPS_LH;
         "LW":    ld_ops = LD_OPS_LW;
         "LBU":   ld_ops = LD_OPS_LBU;
         "LHU":   ld_ops = LD_OPS_LHU;
         "SB":    st_ops = ST_OPS_SB;
         "SH":    st_ops = ST_OPS_SH;
         "SW":    st_ops = ST_OPS_SW;
         default: ;                                         // Caught by the caller
      endcase
      ld_req = (ld_ops != LD_OPS_NONE);
   endtask

   task automatic release_request();
      ld_req = 1'b0;
      ld_ops = LD_OPS_NONE;
      st_ops = ST_OPS_NONE;
   endtask

   task automatic run_test(input int idx);
      int latency;
      int errs_before;
      errs_before = err_cnt;
      @(posedge clk);
      #1;
      drive_request(t_op[idx], t_addr[idx], t_wdata[idx]);
      if (!ld_req && st_ops == ST_OPS_NONE) begin
         $display("test %0d: unknown operation %s, nothing was sent", idx, t_op[idx]);
         fail_cnt++;
         return;
      end
      #3;
      latency = 0;
      while (!lsu_ack) begin
         @(posedge clk);
         #4;
         latency++;
      end
      check_value("lsu_rdata_o", t_rdata[idx], lsu_rdata);
      check_value("lsu_err_o", 32'(t_err[idx]), 32'(lsu_err));
      check_value("ack latency", t_err[idx] ? 0 : 1, latency);  // Mapped acks one edge later
      @(posedge clk);
      #1;
      if (!t_err[idx]) check_value("lsu_ack_o after ack", 32'd0, 32'(lsu_ack));
      release_request();
      if (err_cnt == errs_before) begin
         pass_cnt++;
         $display("test %0d %s %h ok", idx, t_op[idx], t_addr[idx]);
      end else begin
         fail_cnt++;
         $display("test %0d %s %h mismatch", idx, t_op[idx], t_addr[idx]);
      end
   endtask

   initial begin
      rst_n  = 1'b0;
      ld_req = 1'b0;
      ld_ops = LD_OPS_NONE;
      st_ops = ST_OPS_NONE;
      addr   = '0;
      wdata  = '0;
      load_tests();
      cycle_limit = num_tests * 4 + 20;
      repeat (4) @(posedge clk);
      #1 rst_n = 1'b1;
      for (int i = 0; i < num_tests; i++) begin
         run_test(i);
      end
      $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && num_tests > 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule : dbus_subsys_tb

//--- src/dbus_subsys_top.sv
module dbus_subsys_top
   import dbus_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n_i,

   // Load-store unit request
   input  logic                        ld_req_i,
   input  logic [2:0]                  ld_ops_i,
   input  logic [1:0]                  st_ops_i,
   input  logic [DBUS_ADDR_WIDTH-1:0]  addr_i,
   input  logic [DBUS_DATA_WIDTH-1:0]  w_data_i,

   // Response to the load-store unit
   output logic [DBUS_DATA_WIDTH-1:0]  lsu_rdata_o,
   output logic                        lsu_ack_o,
   output logic                        lsu_err_o
);

   logic    unmapped;

   dbus_if  bank_bus [NUM_BANKS] ();

   dbus_interconnect u_dbus_interconnect (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .ld_req_i   (ld_req_i),
      .st_ops_i   (type_st_ops_e'(st_ops_i)),
      .addr_i     (addr_i),
      .w_data_i   (w_data_i),
      .bank_o     (bank_bus),
      .unmapped_o (unmapped)
   );

   // One bank per device region
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      dmem_bank u_dmem_bank (
         .clk     (clk),
         .rst_n_i (rst_n_i),
         .bus_i   (bank_bus[i])
      );
   end

   dbus_load_align u_dbus_load_align (
      .ld_ops_i    (type_ld_ops_e'(ld_ops_i)),
      .addr_i      (addr_i),
      .unmapped_i  (unmapped),
      .bank_i      (bank_bus),
      .lsu_rdata_o (lsu_rdata_o),
      .lsu_ack_o   (lsu_ack_o),
      .lsu_err_o   (lsu_err_o)
   );

endmodule : dbus_subsys_top

//--- src/dbus_load_align.sv
module dbus_load_align
   import dbus_pkg::*;
(
   input  type_ld_ops_e                ld_ops_i,
   input  logic [DBUS_ADDR_WIDTH-1:0]  addr_i,
   input  logic                        unmapped_i,

   dbus_if.rsp                         bank_i [NUM_BANKS],

   output logic [DBUS_DATA_WIDTH-1:0]  lsu_rdata_o,
   output logic                        lsu_ack_o,
   output logic                        lsu_err_o
);

   type_dbus_addr_u              addr;
   logic [NUM_BANKS-1:0]         bank_ack;
   logic [DBUS_DATA_WIDTH-1:0]   bank_rdata [NUM_BANKS];
   logic [DBUS_DATA_WIDTH-1:0]   rdata_sel;
   logic [DBUS_DATA_WIDTH-1:0]   ld_data;
   logic [7:0]                   byte_sel;
   logic [15:0]                  half_sel;

   assign addr.flat = addr_i;

   // Only an ack on a still-strobed bank counts
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_collect
      assign bank_ack[i]   = bank_i[i].ack & bank_i[i].stb;
      assign bank_rdata[i] = bank_i[i].r_data;
   end

   // AND-OR mux over the banks
   always_comb begin
      rdata_sel = '0;
      for (int i = 0; i < NUM_BANKS; i++) begin
         rdata_sel |= bank_rdata[i] & {DBUS_DATA_WIDTH{bank_ack[i]}};
      end
      assert final ($onehot0(bank_ack)) else $error("several banks ack together");
   end

   assign byte_sel = rdata_sel[addr.f.byte_off*8 +: 8];
   assign half_sel = rdata_sel[addr.f.byte_off[1]*16 +: 16];

   // Extension per load type
   always_comb begin
      case (ld_ops_i)
         LD_OPS_LB:  ld_data = {{24{byte_sel[7]}}, byte_sel};
         LD_OPS_LH:  ld_data = {{16{half_sel[15]}}, half_sel};
         LD_OPS_LW:  ld_data = rdata_sel;
         LD_OPS_LBU: ld_data = {24'b0, byte_sel};
         LD_OPS_LHU: ld_data = {16'b0, half_sel};
         default:    ld_data = '0;        // Stores
      endcase
   end

   assign lsu_rdata_o = (|bank_ack) ? ld_data : '0;
   assign lsu_ack_o   = (|bank_ack) | unmapped_i;
   assign lsu_err_o   = unmapped_i;       // Unmapped completes at once

endmodule : dbus_load_align

//--- src/dmem_bank.sv
module dmem_bank
   import dbus_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,

   dbus_if.bank      bus_i
);

   logic [DBUS_DATA_WIDTH-1:0]   mem [BANK_WORDS];
   logic [DBUS_DATA_WIDTH-1:0]   r_data_q;
   logic                         ack_q;
   logic                         access;
   type_dbus_addr_u              addr;

   assign addr   = bus_i.addr;
   // Held stb must not retrigger in the cycle after our own ack
   assign access = bus_i.stb & ~ack_q;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   // Storage and read word
   always_ff @(posedge clk) begin
      if (access) begin
         if (bus_i.w_en) begin
            for (int b = 0; b < DBUS_BYTES; b++) begin
               if (bus_i.sel_byte[b]) begin
                  mem[addr.f.word_idx][b*8 +: 8] <= bus_i.w_data[b*8 +: 8];
               end
            end
         end
         r_data_q <= mem[addr.f.word_idx];   // Old word on a store is ignored
      end
   end

   assign bus_i.r_data = r_data_q;
   assign bus_i.ack    = ack_q;

   // Master holds strobe and address until the ack
   a_req_held: assert property (
      @(posedge clk) disable iff (!rst_n_i)
         (bus_i.stb && !bus_i.ack) |=> (bus_i.stb && $stable(addr.flat))
   ) else $error("request dropped or changed before the bank ack");

endmodule : dmem_bank

//--- src/dbus_interconnect.sv
module dbus_interconnect
   import dbus_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n_i,

   input  logic                        ld_req_i,
   input  type_st_ops_e                st_ops_i,
   input  logic [DBUS_ADDR_WIDTH-1:0]  addr_i,
   input  logic [DBUS_DATA_WIDTH-1:0]  w_data_i,

   dbus_if.master                      bank_o [NUM_BANKS],
   output logic                        unmapped_o
);

   type_dbus_addr_u              addr;
   logic                         st_req;
   logic                         dbus_req;
   logic [NUM_BANKS-1:0]         bank_stb;
   logic [DBUS_DATA_WIDTH-1:0]   w_data;
   logic [DBUS_BYTES-1:0]        sel_byte;

   assign addr.flat = addr_i;
   assign st_req    = (st_ops_i != ST_OPS_NONE);
   assign dbus_req  = ld_req_i | st_req;

   // Store lane steering
   always_comb begin
      w_data   = '0;
      sel_byte = '0;
      case (st_ops_i)
         ST_OPS_SB: begin
            w_data[addr.f.byte_off*8 +: 8] = w_data_i[7:0];
            sel_byte[addr.f.byte_off]      = 1'b1;
         end
         ST_OPS_SH: begin
            if (addr.f.byte_off[1]) begin        // Upper half
               w_data[31:16] = w_data_i[15:0];
               sel_byte      = 4'b1100;
            end else begin
               w_data[15:0]  = w_data_i[15:0];
               sel_byte      = 4'b0011;
            end
         end
         ST_OPS_SW: begin
            w_data   = w_data_i;
            sel_byte = '1;
         end
         default: begin
            w_data   = '0;
            sel_byte = '0;
         end
      endcase
   end

   // One region per bank and the same request fields fanned out to all
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank_sel
      assign bank_stb[i] = dbus_req &
                           (addr.f.dev == DEV_SEL_WIDTH'(BANK_ADDR_MATCH_BASE + i));

      assign bank_o[i].addr     = addr;
      assign bank_o[i].w_data   = w_data;
      assign bank_o[i].sel_byte = sel_byte;
      assign bank_o[i].w_en     = st_req;
      assign bank_o[i].stb      = bank_stb[i];
   end

   // Request that hits no bank region
   assign unmapped_o = dbus_req & ~(|bank_stb);

   // A request is either a load or a store
   a_ld_st_excl: assert property (
      @(posedge clk) disable iff (!rst_n_i) !(ld_req_i && st_req)
   ) else $error("load and store requested together");

endmodule : dbus_interconnect

//--- src/dbus_if.sv
interface dbus_if
   import dbus_pkg::*;
   ();

   // Request side
   type_dbus_addr_u              addr;
   logic [DBUS_DATA_WIDTH-1:0]   w_data;
   logic [DBUS_BYTES-1:0]        sel_byte;
   logic                         w_en;
   logic                         stb;

   // Response side
   logic [DBUS_DATA_WIDTH-1:0]   r_data;
   logic                         ack;

   modport master (
      output addr, w_data, sel_byte, w_en, stb
   );

   modport bank (
      input  addr, w_data, sel_byte, w_en, stb,
      output r_data, ack
   );

   // Read-only view for the response collector
   modport rsp (
      input stb, ack, r_data
   );

endinterface : dbus_if

//--- src/dbus_pkg.sv
package dbus_pkg;

   // Bus widths
   localparam int DBUS_ADDR_WIDTH = 32;
   localparam int DBUS_DATA_WIDTH = 32;
   localparam int DBUS_BYTES      = DBUS_DATA_WIDTH / 8;

   // Device select field of the address
   localparam int DEV_SEL_ADDR_HIGH = 31;
   localparam int DEV_SEL_ADDR_LOW  = 28;
   localparam int DEV_SEL_WIDTH     = DEV_SEL_ADDR_HIGH - DEV_SEL_ADDR_LOW + 1;

   // Bank geometry
   localparam int NUM_BANKS      = 4;
   localparam int BANK_WORDS     = 256;
   localparam int WORD_IDX_WIDTH = $clog2(BANK_WORDS);
   localparam int BYTE_OFF_WIDTH = $clog2(DBUS_BYTES);
   localparam int ADDR_PAD_WIDTH = DBUS_ADDR_WIDTH - DEV_SEL_WIDTH - WORD_IDX_WIDTH
                                   - BYTE_OFF_WIDTH;

   // Bank k answers to device field BANK_ADDR_MATCH_BASE + k
   localparam int BANK_ADDR_MATCH_BASE = 1;

   typedef enum logic [1:0] {
      ST_OPS_NONE = 2'b00,
      ST_OPS_SB   = 2'b01,
      ST_OPS_SH   = 2'b10,
      ST_OPS_SW   = 2'b11
   } type_st_ops_e;

   typedef enum logic [2:0] {
      LD_OPS_NONE = 3'b000,
      LD_OPS_LB   = 3'b001,
      LD_OPS_LH   = 3'b010,
      LD_OPS_LW   = 3'b011,
      LD_OPS_LBU  = 3'b100,
      LD_OPS_LHU  = 3'b101
   } type_ld_ops_e;

   // Same address word, seen flat or split into its decode fields
   typedef union packed {
      logic [DBUS_ADDR_WIDTH-1:0] flat;
      struct packed {
         logic [DEV_SEL_WIDTH-1:0]  dev;       // Device / bank select
         logic [ADDR_PAD_WIDTH-1:0] unused;
         logic [WORD_IDX_WIDTH-1:0] word_idx;  // Word inside a bank
         logic [BYTE_OFF_WIDTH-1:0] byte_off;  // Lane offset
      } f;
   } type_dbus_addr_u;

endpackage : dbus_pkg
